// ==== compile.f ====
src/detPkg.sv
src/detCommand.sv
src/matrixLoader.sv
src/matrixRam.sv
src/bareissEngine.sv
src/exactDivider.sv
src/detTop.sv
verif/memSlave.sv
verif/tbDet.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbDet -f compile.f -o simDet
./obj_dir/simDet > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0

// ==== verif/tbDet.sv ====
// testbench for the determinant coprocessor; random matrices checked against a Bareiss model
`timescale 1ns/1ps

module tbDet;

    localparam int CASES   = 24;
    localparam int TIMEOUT = 40000;  // about 1600 cycles per case
    localparam logic [15:0] SEED = 16'd20;

    logic clk;
    logic rst;
    logic start;
    logic [31:0] dataA;
    logic [31:0] dataB;
    logic resultRead;
    logic done;
    logic [31:0] result;
    logic [31:0] resultReadData;
    logic irq;
    logic [detPkg::ADDR_W-1:0] address;
    logic read;
    logic [31:0] readData;
    logic readDataValid;
    logic waitRequest;
    logic waitIn;
    logic fillEn;
    logic [5:0] fillIdx;
    logic [31:0] fillData;

    logic [15:0] dataLfsr;
    logic [15:0] waitLfsr;
    int mat [16];
    int errors;
    int checks;
    int cycleCount;
    int beats;
    int expBeats;
    int curBase;
    bit readAllowed;

    detTop UUT (
        .clk, .rst, .dataA, .dataB, .start, .done, .result, .address, .read,
        .readData, .readDataValid, .waitRequest, .resultRead, .resultReadData, .irq
    );

    memSlave mem (
        .clk, .rst, .address, .read, .waitIn, .fillEn, .fillIdx, .fillData,
        .waitRequest, .readData, .readDataValid
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);  // galois form with taps 16 14 13 11
    endfunction

    task automatic takeBits(input int count, output int val);
        val = 0;
        repeat (count) begin
            val = (val << 1) | int'(dataLfsr[0]);
            dataLfsr = lfsrNext(dataLfsr);
        end
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, $signed(got),
                     $signed(exp));
        end
    endtask

    // fraction-free elimination without row swaps
    function automatic logic [31:0] modelDet(input int n);
        longint a [16];
        longint prev;
        for (int idx = 0; idx < 16; idx++) a[idx] = mat[idx];
        prev = 1;
        for (int k = 0; k < n - 1; k++) begin
            if (a[k*n+k] == 0) return detPkg::SINGULAR_MARK;
            for (int i = k + 1; i < n; i++) begin
                for (int j = k + 1; j < n; j++) begin
                    a[i*n+j] = (a[k*n+k] * a[i*n+j] - a[i*n+k] * a[k*n+j]) / prev;
                end
            end
            prev = a[k*n+k];
        end
        return 32'(a[n*n-1]);
    endfunction

    task automatic fillMatrix(input int wordBase, input int n);
        for (int idx = 0; idx < n * n; idx++) begin
            @(posedge clk);
            fillEn   <= 1'b1;
            fillIdx  <= 6'(wordBase + idx);
            fillData <= mat[idx];
        end
        @(posedge clk);
        fillEn <= 1'b0;
    endtask

    task automatic sendStart(input logic [31:0] addr, input logic [31:0] dimVal,
                             input logic [31:0] expStatus, input string what);
        @(posedge clk);
        start <= 1'b1;
        dataA <= addr;
        dataB <= dimVal;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        checkEq(done, 1, {what, " done"});
        checkEq(result, expStatus, {what, " status"});
        @(negedge clk);
        checkEq(done, 0, "done without start");
        checkEq(result, 0, "result without start");
    endtask

    task automatic readResult(input logic [31:0] expDet);
        @(posedge clk);
        resultRead <= 1'b1;
        @(posedge clk);
        resultRead <= 1'b0;
        @(negedge clk);
        checkEq(resultReadData, expDet, "determinant");
        checkEq(irq, 0, "irq after readout");
    endtask

    task automatic runCase(input int c);
        int n;
        int r;
        int wordBase;
        logic [31:0] expDet;
        n = 2 + c % 3;
        @(posedge clk);
        takeBits(5, wordBase);
        for (int idx = 0; idx < n * n; idx++) begin
            takeBits(6, r);
            mat[idx] = r - 32;
        end
        if (c % 6 == 5) mat[0] = 0;  // zero leading pivot
        expDet = modelDet(n);
        fillMatrix(wordBase, n);
        curBase     = wordBase * 4;
        expBeats    = n * n;
        beats       = 0;
        readAllowed = 1'b1;
        sendStart(curBase, n, detPkg::stAccepted, "valid start");
        sendStart(curBase, n, detPkg::stLoading, "start while loading");
        checkEq(read, 1, "read during loading");
        while (beats < expBeats) @(posedge clk);
        if (mat[0] != 0) begin
            repeat (8) @(negedge clk);  // engine has taken go by now
            checkEq(irq, 0, "irq during calculation");
            sendStart(curBase, n, detPkg::stCalc, "start while calculating");
        end
        while (!irq) @(negedge clk);
        sendStart(curBase, 3, detPkg::stWaitRead, "start while waiting");
        readResult(expDet);
        checkEq(beats, expBeats, "beat count");
        readAllowed = 1'b0;
    endtask

    // random stall bit for the memory model
    initial begin
        forever begin
            @(posedge clk);
            waitIn <= waitLfsr[0];
            waitLfsr = lfsrNext(waitLfsr);
        end
    end

    // watch accepted read beats
    always @(negedge clk) begin
        if (!rst && read) begin
            assert (readAllowed) else begin
                errors++;
                $display("read request seen at %0t with no accepted command", $time);
            end
            if (!waitRequest) begin
                assert (beats < expBeats) else begin
                    errors++;
                    $display("more read beats than the matrix has, at %0t", $time);
                end
                checkEq(address, 24'(curBase + 4 * beats), "read address");
                beats++;
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not end within %0d cycles", TIMEOUT);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        dataA       = '0;
        dataB       = '0;
        resultRead  = 1'b0;
        waitIn      = 1'b0;
        fillEn      = 1'b0;
        fillIdx     = '0;
        fillData    = '0;
        dataLfsr    = SEED;
        waitLfsr    = SEED;
        errors      = 0;
        checks      = 0;
        beats       = 0;
        expBeats    = 0;
        curBase     = 0;
        readAllowed = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkEq(done, 0, "done after reset");
        checkEq(irq, 0, "irq after reset");
        checkEq(read, 0, "read after reset");
        checkEq(result, 0, "result after reset");
        checkEq(resultReadData, 0, "resultReadData after reset");
        // bad dimensions only poll the status
        sendStart(32'h40, 0, detPkg::stReady, "dimension 0");
        sendStart(32'h40, 1, detPkg::stReady, "dimension 1");
        sendStart(32'h40, 5, detPkg::stReady, "dimension 5");
        repeat (10) @(negedge clk);
        for (int c = 0; c < CASES; c++) runCase(c);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verif/memSlave.sv ====
// testbench Avalon memory model; random waitRequest, read data two cycles after acceptance
`timescale 1ns/1ps

module memSlave (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [detPkg::ADDR_W-1:0]   address,
    input  logic                        read,
    input  logic                        waitIn,
    input  logic                        fillEn,
    input  logic [5:0]                  fillIdx,
    input  logic [detPkg::WORD_W-1:0]   fillData,
    output logic                        waitRequest,
    output logic [detPkg::WORD_W-1:0]   readData,
    output logic                        readDataValid
);

    logic [detPkg::WORD_W-1:0] words [64];
    logic pipeValid;
    logic [detPkg::WORD_W-1:0] pipeData;

    assign waitRequest = waitIn;  // stall bit comes straight from the testbench

    always_ff @(posedge clk) begin
        if (fillEn) words[fillIdx] <= fillData;
        if (rst) begin
            pipeValid     <= 1'b0;
            readDataValid <= 1'b0;
        end else begin
            pipeValid     <= read && !waitRequest;  // accepted beat
            pipeData      <= words[address[7:2]];
            readDataValid <= pipeValid;
            readData      <= pipeData;
        end
    end

endmodule

// ==== src/detTop.sv ====
// determinant coprocessor top; processor command port, Avalon read master and irq
`timescale 1ns/1ps

module detTop (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [detPkg::WORD_W-1:0]   dataA,
    input  logic [detPkg::WORD_W-1:0]   dataB,
    input  logic                        start,
    output logic                        done,
    output logic [detPkg::WORD_W-1:0]   result,
    output logic [detPkg::ADDR_W-1:0]   address,
    output logic                        read,
    input  logic [detPkg::WORD_W-1:0]   readData,
    input  logic                        readDataValid,
    input  logic                        waitRequest,
    input  logic                        resultRead,
    output logic [detPkg::WORD_W-1:0]   resultReadData,
    output logic                        irq
);

    logic load, loaded, go, finished, singular;
    logic [detPkg::ADDR_W-1:0] baseAddr;
    logic [detPkg::DIM_W-1:0] dim;
    logic [detPkg::WORD_W-1:0] det;
    logic loadWrEn, calcWrEn;
    logic [detPkg::RAM_ADDR_W-1:0] loadWrAddr, calcWrAddr, rdAddr;
    logic [detPkg::WORD_W-1:0] loadWrData, calcWrData, rdData;
    logic divStart, divDone;
    logic [2*detPkg::WORD_W-1:0] divNum;
    logic [detPkg::WORD_W-1:0] divDen, divQuot;

    detCommand cmd (
        .clk, .rst, .start, .dataA, .dataB, .loaded, .finished,
        .detIn(det), .singular, .resultRead, .done, .result, .load,
        .baseAddr, .dim, .go, .irq, .resultReadData
    );

    matrixLoader loader (
        .clk, .rst, .load, .baseAddr, .dim, .readData, .readDataValid, .waitRequest,
        .address, .read, .ramWrEn(loadWrEn), .ramWrAddr(loadWrAddr),
        .ramWrData(loadWrData), .loaded
    );

    matrixRam ram (
        .clk, .loadWrEn, .loadWrAddr, .loadWrData,
        .calcWrEn, .calcWrAddr, .calcWrData, .rdAddr, .rdData
    );

    bareissEngine engine (
        .clk, .rst, .go, .dim, .rdData, .divDone, .divQuot, .rdAddr,
        .wrEn(calcWrEn), .wrAddr(calcWrAddr), .wrData(calcWrData),
        .divStart, .divNum, .divDen, .finished, .det, .singular
    );

    exactDivider divider (
        .clk, .rst, .divStart, .divNum, .divDen, .divDone, .divQuot
    );

endmodule

// ==== src/exactDivider.sv ====
// sequential signed divider, 64-bit by 32-bit, restoring; quotient 65 cycles after divStart
`timescale 1ns/1ps

module exactDivider (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            divStart,
    input  logic [2*detPkg::WORD_W-1:0]     divNum,
    input  logic [detPkg::WORD_W-1:0]       divDen,
    output logic                            divDone,
    output logic [detPkg::WORD_W-1:0]       divQuot
);

    logic [2*detPkg::WORD_W-1:0] quo, nextQuo;  // shifts in quotient bits
    logic [detPkg::WORD_W-1:0] rem, nextRem;  // stays below the divisor
    logic [detPkg::WORD_W:0] remShift;
    logic [detPkg::WORD_W+1:0] trial;
    logic [detPkg::WORD_W-1:0] den;
    logic negQ;
    logic busy;
    logic [6:0] count;

    always_comb begin
        remShift = {rem, quo[2*detPkg::WORD_W-1]};
        trial    = {1'b0, remShift} - {2'b00, den};
        if (trial[detPkg::WORD_W+1]) begin
            nextRem = remShift[detPkg::WORD_W-1:0];  // restore on borrow
            nextQuo = {quo[2*detPkg::WORD_W-2:0], 1'b0};
        end else begin
            nextRem = trial[detPkg::WORD_W-1:0];
            nextQuo = {quo[2*detPkg::WORD_W-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            divDone <= 1'b0;
            count   <= '0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                busy  <= 1'b1;
                count <= 7'd64;
            end else if (busy) begin
                count <= count - 1;
                if (count == 7'd1) begin
                    busy    <= 1'b0;
                    divDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin
            quo  <= divNum[2*detPkg::WORD_W-1] ? -divNum : divNum;
            den  <= divDen[detPkg::WORD_W-1] ? -divDen : divDen;
            rem  <= '0;
            negQ <= divNum[2*detPkg::WORD_W-1] ^ divDen[detPkg::WORD_W-1];
        end else if (busy) begin
            quo <= nextQuo;
            rem <= nextRem;
            // low word holds the whole quotient as the division is exact
            if (count == 7'd1) begin
                divQuot <= negQ ? -nextQuo[detPkg::WORD_W-1:0] : nextQuo[detPkg::WORD_W-1:0];
            end
        end
    end

endmodule

// ==== src/bareissEngine.sv ====
// Bareiss fraction-free elimination over the matrix RAM; one divide per updated cell
`timescale 1ns/1ps

module bareissEngine (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            go,
    input  logic [detPkg::DIM_W-1:0]        dim,
    input  logic [detPkg::WORD_W-1:0]       rdData,
    input  logic                            divDone,
    input  logic [detPkg::WORD_W-1:0]       divQuot,
    output logic [detPkg::RAM_ADDR_W-1:0]   rdAddr,
    output logic                            wrEn,
    output logic [detPkg::RAM_ADDR_W-1:0]   wrAddr,
    output logic [detPkg::WORD_W-1:0]       wrData,
    output logic                            divStart,
    output logic [2*detPkg::WORD_W-1:0]     divNum,
    output logic [detPkg::WORD_W-1:0]       divDen,
    output logic                            finished,
    output logic [detPkg::WORD_W-1:0]       det,
    output logic                            singular
);

    detPkg::engStateT state;
    logic [detPkg::DIM_W-1:0] k, i, j;
    logic [detPkg::DIM_W-1:0] dimLast;
    logic [1:0] fetchCnt;
    logic signed [detPkg::WORD_W-1:0] pivot, prevPivot, aij, aik, akj;
    logic signed [2*detPkg::WORD_W-1:0] crossTerm;

    // row-major cell index
    function automatic logic [detPkg::RAM_ADDR_W-1:0] cellAddr(
        input logic [detPkg::DIM_W-1:0] r,
        input logic [detPkg::DIM_W-1:0] c
    );
        cellAddr = {1'b0, r} * {1'b0, dim} + {1'b0, c};
    endfunction

    assign dimLast = dim - 1;
    assign akj = rdData;
    assign crossTerm = (2*detPkg::WORD_W)'(pivot) * (2*detPkg::WORD_W)'(aij)
                     - (2*detPkg::WORD_W)'(aik) * (2*detPkg::WORD_W)'(akj);

    always_comb begin
        if (state == detPkg::esFetch) begin
            case (fetchCnt)
                2'd1:    rdAddr = cellAddr(i, k);
                2'd2:    rdAddr = cellAddr(k, j);
                default: rdAddr = cellAddr(i, j);
            endcase
        end else begin
            rdAddr = cellAddr(k, k);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= detPkg::esIdle;
            wrEn     <= 1'b0;
            divStart <= 1'b0;
            finished <= 1'b0;
            singular <= 1'b0;
        end else begin
            wrEn     <= 1'b0;
            divStart <= 1'b0;
            finished <= 1'b0;
            case (state)
                detPkg::esIdle: begin
                    if (go) begin
                        k         <= '0;
                        prevPivot <= 1;  // first divide is by one
                        state     <= detPkg::esPivot;
                    end
                end
                detPkg::esPivot: state <= detPkg::esCheck;
                detPkg::esCheck: begin
                    if (rdData == '0) begin
                        singular <= 1'b1;  // no row swap, give up
                        det      <= '0;
                        finished <= 1'b1;
                        state    <= detPkg::esIdle;
                    end else begin
                        pivot    <= rdData;
                        i        <= k + 1;
                        j        <= k + 1;
                        fetchCnt <= '0;
                        state    <= detPkg::esFetch;
                    end
                end
                detPkg::esFetch: begin
                    fetchCnt <= fetchCnt + 1;
                    if (fetchCnt == 2'd1) aij <= rdData;
                    if (fetchCnt == 2'd2) aik <= rdData;
                    if (fetchCnt == 2'd3) begin
                        divNum   <= crossTerm;
                        divDen   <= prevPivot;
                        divStart <= 1'b1;
                        state    <= detPkg::esWait;
                    end
                end
                default: begin
                    if (divDone) begin
                        wrEn     <= 1'b1;
                        wrAddr   <= cellAddr(i, j);
                        wrData   <= divQuot;
                        fetchCnt <= '0;
                        if (j != dimLast) begin
                            j     <= j + 1;
                            state <= detPkg::esFetch;
                        end else if (i != dimLast) begin
                            i     <= i + 1;
                            j     <= k + 1;
                            state <= detPkg::esFetch;
                        end else if (k + 1 == dimLast) begin
                            det      <= divQuot;  // bottom-right cell is the determinant
                            singular <= 1'b0;
                            finished <= 1'b1;
                            state    <= detPkg::esIdle;
                        end else begin
                            k         <= k + 1;
                            prevPivot <= pivot;
                            state     <= detPkg::esPivot;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== src/matrixRam.sv ====
// matrix storage, 16 words, registered read; written by the loader and the engine
`timescale 1ns/1ps

module matrixRam (
    input  logic                            clk,
    input  logic                            loadWrEn,
    input  logic [detPkg::RAM_ADDR_W-1:0]   loadWrAddr,
    input  logic [detPkg::WORD_W-1:0]       loadWrData,
    input  logic                            calcWrEn,
    input  logic [detPkg::RAM_ADDR_W-1:0]   calcWrAddr,
    input  logic [detPkg::WORD_W-1:0]       calcWrData,
    input  logic [detPkg::RAM_ADDR_W-1:0]   rdAddr,
    output logic [detPkg::WORD_W-1:0]       rdData
);

    logic [detPkg::WORD_W-1:0] mem [detPkg::RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (loadWrEn) mem[loadWrAddr] <= loadWrData;  // loader wins
        else if (calcWrEn) mem[calcWrAddr] <= calcWrData;
        rdData <= mem[rdAddr];
    end

endmodule

// ==== src/matrixLoader.sv ====
// Avalon read master; fetches n*n words from base address into the matrix RAM
`timescale 1ns/1ps

module matrixLoader (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  logic [detPkg::ADDR_W-1:0]       baseAddr,
    input  logic [detPkg::DIM_W-1:0]        dim,
    input  logic [detPkg::WORD_W-1:0]       readData,
    input  logic                            readDataValid,
    input  logic                            waitRequest,
    output logic [detPkg::ADDR_W-1:0]       address,
    output logic                            read,
    output logic                            ramWrEn,
    output logic [detPkg::RAM_ADDR_W-1:0]   ramWrAddr,
    output logic [detPkg::WORD_W-1:0]       ramWrData,
    output logic                            loaded
);

    logic [detPkg::RAM_ADDR_W:0] wordCount;  // up to 16 words
    logic [detPkg::RAM_ADDR_W:0] reqCnt;
    logic [detPkg::RAM_ADDR_W:0] rcvCnt;
    logic rcvActive;
    logic lastWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            address   <= '0;
            read      <= 1'b0;
            ramWrEn   <= 1'b0;
            loaded    <= 1'b0;
            rcvActive <= 1'b0;
            lastWord  <= 1'b0;
            reqCnt    <= '0;
            rcvCnt    <= '0;
            wordCount <= '0;
        end else begin
            ramWrEn  <= 1'b0;
            loaded   <= lastWord;  // one cycle after the last RAM write
            lastWord <= 1'b0;

            // request side
            if (load) begin
                address   <= baseAddr;
                read      <= 1'b1;
                reqCnt    <= '0;
                wordCount <= {2'b00, dim} * {2'b00, dim};
            end else if (read && !waitRequest) begin
                address <= address + 4;  // beat accepted
                reqCnt  <= reqCnt + 1;
                if (reqCnt == wordCount - 1) read <= 1'b0;
            end

            // receive side, responses come back in order
            if (load) begin
                rcvCnt    <= '0;
                rcvActive <= 1'b1;
            end else if (rcvActive && readDataValid) begin
                ramWrEn   <= 1'b1;
                ramWrAddr <= rcvCnt[detPkg::RAM_ADDR_W-1:0];
                ramWrData <= readData;
                rcvCnt    <= rcvCnt + 1;
                if (rcvCnt == wordCount - 1) begin
                    rcvActive <= 1'b0;
                    lastWord  <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/detCommand.sv ====
// command decoder and phase sequencer; answers start pulses and holds the result behind irq
`timescale 1ns/1ps

module detCommand (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [detPkg::WORD_W-1:0]   dataA,
    input  logic [detPkg::WORD_W-1:0]   dataB,
    input  logic                        loaded,
    input  logic                        finished,
    input  logic [detPkg::WORD_W-1:0]   detIn,
    input  logic                        singular,
    input  logic                        resultRead,
    output logic                        done,
    output logic [detPkg::WORD_W-1:0]   result,
    output logic                        load,
    output logic [detPkg::ADDR_W-1:0]   baseAddr,
    output logic [detPkg::DIM_W-1:0]    dim,
    output logic                        go,
    output logic                        irq,
    output logic [detPkg::WORD_W-1:0]   resultReadData
);

    detPkg::phaseT phase;
    logic [detPkg::WORD_W-1:0] detHold;
    logic dimOk;

    assign dimOk = (dataB >= 2) && (dataB <= detPkg::MAX_DIM);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase          <= detPkg::phIdle;
            done           <= 1'b0;
            result         <= '0;
            load           <= 1'b0;
            go             <= 1'b0;
            irq            <= 1'b0;
            resultReadData <= '0;
        end else begin
            done   <= start;  // every start is answered next cycle
            result <= '0;
            load   <= 1'b0;
            go     <= 1'b0;
            case (phase)
                detPkg::phIdle: begin
                    if (start && dimOk) begin
                        result <= detPkg::stAccepted;
                        load   <= 1'b1;
                        phase  <= detPkg::phLoad;
                    end else if (start) begin
                        result <= detPkg::stReady;  // bad dimension doubles as status poll
                    end
                end
                detPkg::phLoad: begin
                    if (start) result <= detPkg::stLoading;
                    if (loaded) begin
                        go    <= 1'b1;
                        phase <= detPkg::phCalc;
                    end
                end
                detPkg::phCalc: begin
                    if (start) result <= detPkg::stCalc;
                    if (finished) begin
                        irq   <= 1'b1;
                        phase <= detPkg::phWaitRead;
                    end
                end
                default: begin
                    if (start) result <= detPkg::stWaitRead;
                    if (resultRead) begin
                        resultReadData <= detHold;
                        irq            <= 1'b0;
                        phase          <= detPkg::phIdle;
                    end
                end
            endcase
        end
    end

    // run parameters and result hold
    always_ff @(posedge clk) begin
        if (phase == detPkg::phIdle && start && dimOk) begin
            baseAddr <= dataA[detPkg::ADDR_W-1:0];
            dim      <= dataB[detPkg::DIM_W-1:0];
        end
        if (phase == detPkg::phCalc && finished) begin
            detHold <= singular ? detPkg::SINGULAR_MARK : detIn;
        end
    end

endmodule

// ==== src/detPkg.sv ====
// shared sizes, status codes and state encodings for the determinant coprocessor
package detPkg;

    localparam int MAX_DIM    = 4;
    localparam int RAM_DEPTH  = MAX_DIM * MAX_DIM;
    localparam int RAM_ADDR_W = 4;
    localparam int DIM_W      = 3;
    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 24;

    // returned instead of a determinant when a zero pivot shows up
    localparam logic [WORD_W-1:0] SINGULAR_MARK = 32'h8000_0000;

    // answers to a start pulse
    typedef enum logic [31:0] {
        stReady    = 32'd0,
        stLoading  = 32'd1,
        stCalc     = 32'd2,
        stWaitRead = 32'd3,
        stAccepted = 32'd99
    } statusT;

    typedef enum logic [1:0] {
        phIdle,
        phLoad,
        phCalc,
        phWaitRead
    } phaseT;

    typedef enum logic [2:0] {
        esIdle,
        esPivot,  // pivot address on the RAM
        esCheck,  // pivot data back
        esFetch,  // three operand reads
        esWait    // divider busy
    } engStateT;

endpackage
